// ==== rtl/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

  // request address layout, word granular
  localparam int ROW_W  = 12;
  localparam int BANK_W = 2;
  localparam int COL_W  = 12;
  localparam int ADDR_W = ROW_W + BANK_W + COL_W;   // 26
  localparam int SA_W   = 13;                        // SDRAM address pins
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // A10 high selects all banks
  localparam logic [SA_W-1:0] PRCH_ALL_ADDR = 13'h0400;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    ARSR = 3'b001,   // auto refresh
    PRCH = 3'b010,   // precharge
    ACTV = 3'b011,   // row open
    WRTE = 3'b100,
    READ = 3'b101,
    NOOP = 3'b111
  } sdram_cmd_e;

  typedef struct packed {
    logic              req;     // level, held until grant
    logic              write;
    logic [ADDR_W-1:0] addr;    // row, bank, column
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } port_req_t;

  typedef struct packed {
    sdram_cmd_e        cmd;
    logic [BANK_W-1:0] bank;
    logic [SA_W-1:0]   addr;
  } sdram_pins_t;

  typedef struct packed {
    logic              rd;      // one cycle strobes
    logic              wr;
    logic              bulk;    // granted port
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } dp_op_t;

endpackage

`default_nettype wire

// ==== rtl/refresh_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
  parameter int REFRESH_CYCLES = 200
) (
  input  wire  CLK,
  input  wire  RST,
  input  wire  refresh_ack,
  output logic refresh_due
);

  localparam int CNT_W = $clog2(REFRESH_CYCLES + 1);

  logic [CNT_W-1:0] count;

  // due stays up until acked, a late refresh is still served
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      count       <= CNT_W'(REFRESH_CYCLES - 1);
      refresh_due <= 1'b0;
    end
    else if (refresh_ack)
    begin
      count       <= CNT_W'(REFRESH_CYCLES - 1);   // restart interval
      refresh_due <= 1'b0;
    end
    else if (count == '0)
    begin
      refresh_due <= 1'b1;   // hold at zero until ack
    end
    else
    begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/command_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_sequencer #(
  parameter int T_RP  = 2,
  parameter int T_RCD = 2,
  parameter int T_RFC = 6
) (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire sdram_pkg::port_req_t req_rand,
  input  wire sdram_pkg::port_req_t req_bulk,
  input  wire                     refresh_due,
  output logic                    refresh_ack,
  output sdram_pkg::sdram_pins_t  pins,
  output logic                    grant_rand,
  output logic                    grant_bulk,
  output sdram_pkg::dp_op_t       dp_op
);

  localparam int ROW_W  = sdram_pkg::ROW_W;
  localparam int BANK_W = sdram_pkg::BANK_W;
  localparam int COL_W  = sdram_pkg::COL_W;
  localparam int ADDR_W = sdram_pkg::ADDR_W;
  localparam int SA_W   = sdram_pkg::SA_W;

  localparam int MAX_A    = (T_RP > T_RCD) ? T_RP : T_RCD;
  localparam int WAIT_MAX = (T_RFC > MAX_A) ? T_RFC : MAX_A;
  localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

  // open page
  logic              page_valid;
  logic [BANK_W-1:0] page_bank;
  logic [ROW_W-1:0]  page_row;

  logic [WAIT_W-1:0] wait_cnt;   // NOOP cycles still owed

  // arbitration and decode of the winner
  sdram_pkg::port_req_t sel;
  logic                 sel_bulk;
  logic                 any_req;
  logic [ROW_W-1:0]     req_row;
  logic [BANK_W-1:0]    req_bank;
  logic [COL_W-1:0]     req_col;
  logic                 page_hit;

  // decision for the next cycle on pins
  sdram_pkg::sdram_pins_t next_pins;
  logic [WAIT_W-1:0]      next_wait;
  logic                   issue_rd;
  logic                   issue_wr;

  assign sel_bulk = req_bulk.req;                  // bulk wins over random
  assign sel      = sel_bulk ? req_bulk : req_rand;
  assign any_req  = req_bulk.req | req_rand.req;

  assign req_row  = sel.addr[ADDR_W-1 -: ROW_W];
  assign req_bank = sel.addr[COL_W +: BANK_W];
  assign req_col  = sel.addr[COL_W-1:0];

  assign page_hit = page_valid && (page_bank == req_bank) && (page_row == req_row);

  always_comb
  begin
    next_pins.cmd  = sdram_pkg::NOOP;
    next_pins.bank = page_bank;
    next_pins.addr = sdram_pkg::PRCH_ALL_ADDR;
    next_wait      = '0;
    if (wait_cnt == '0)
    begin
      if (refresh_due)
      begin
        if (page_valid)
        begin
          next_pins.cmd = sdram_pkg::PRCH;         // close page before refresh
          next_wait     = WAIT_W'(T_RP);
        end
        else
        begin
          next_pins.cmd = sdram_pkg::ARSR;
          next_wait     = WAIT_W'(T_RFC);
        end
      end
      else if (any_req)
      begin
        if (page_hit)
        begin
          next_pins.cmd  = sel.write ? sdram_pkg::WRTE : sdram_pkg::READ;
          next_pins.bank = req_bank;
          // column around A10, A10 low means no auto precharge
          next_pins.addr = {req_col[COL_W-1:10], 1'b0, req_col[9:0]};
          next_wait      = WAIT_W'(1);
        end
        else if (page_valid)
        begin
          next_pins.cmd = sdram_pkg::PRCH;         // miss on open page
          next_wait     = WAIT_W'(T_RP);
        end
        else
        begin
          next_pins.cmd  = sdram_pkg::ACTV;
          next_pins.bank = req_bank;
          next_pins.addr = {{(SA_W - ROW_W){1'b0}}, req_row};
          next_wait      = WAIT_W'(T_RCD);
        end
      end
    end
  end

  assign issue_rd    = (next_pins.cmd == sdram_pkg::READ);
  assign issue_wr    = (next_pins.cmd == sdram_pkg::WRTE);
  assign refresh_ack = (next_pins.cmd == sdram_pkg::ARSR);

  // datapath strobe, registered there together with pins here
  assign dp_op.rd    = issue_rd;
  assign dp_op.wr    = issue_wr;
  assign dp_op.bulk  = sel_bulk;
  assign dp_op.wdata = sel.wdata;
  assign dp_op.be    = sel.be;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      pins.cmd   <= sdram_pkg::NOOP;
      pins.bank  <= '0;
      pins.addr  <= sdram_pkg::PRCH_ALL_ADDR;
      grant_rand <= 1'b0;
      grant_bulk <= 1'b0;
      wait_cnt   <= '0;
      page_valid <= 1'b0;
    end
    else
    begin
      pins       <= next_pins;
      grant_rand <= (issue_rd | issue_wr) & ~sel_bulk;   // with READ/WRITE on pins
      grant_bulk <= (issue_rd | issue_wr) & sel_bulk;
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;
      else
        wait_cnt <= next_wait;
      case (next_pins.cmd)
        sdram_pkg::ACTV: page_valid <= 1'b1;
        sdram_pkg::PRCH: page_valid <= 1'b0;
        default:         page_valid <= page_valid;
      endcase
    end
  end

  // page address, only looked at while page_valid
  always_ff @(posedge CLK)
  begin
    if (next_pins.cmd == sdram_pkg::ACTV)
    begin
      page_bank <= req_bank;
      page_row  <= req_row;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dq_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dq_datapath #(
  parameter int CAS_LATENCY = 2
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire sdram_pkg::dp_op_t         dp_op,
  input  wire [sdram_pkg::DATA_W-1:0]    dq_in,
  output logic [sdram_pkg::DATA_W-1:0]   dq_out,
  output logic                           dq_oe,
  output logic [sdram_pkg::BE_W-1:0]     dm,
  output logic [sdram_pkg::DATA_W-1:0]   rd_data,
  output logic                           rd_valid_rand,
  output logic                           rd_valid_bulk
);

  // read tags in flight, index i is i cycles after READ on pins
  logic [CAS_LATENCY-1:0] pipe_vld;
  logic [CAS_LATENCY-1:0] pipe_bulk;
  logic                   rd_done;
  logic                   rd_done_bulk;

  assign rd_done      = pipe_vld[CAS_LATENCY-1];
  assign rd_done_bulk = pipe_bulk[CAS_LATENCY-1];

  // write drive lines up with WRITE on pins
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      dq_oe <= 1'b0;
      dm    <= '1;   // all bytes masked
    end
    else
    begin
      dq_oe <= dp_op.wr;
      dm    <= dp_op.wr ? ~dp_op.be : '1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (dp_op.wr)
      dq_out <= dp_op.wdata;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      pipe_vld      <= '0;
      rd_valid_rand <= 1'b0;
      rd_valid_bulk <= 1'b0;
    end
    else
    begin
      pipe_vld[0] <= dp_op.rd;
      for (int i = 1; i < CAS_LATENCY; i++)
        pipe_vld[i] <= pipe_vld[i-1];
      rd_valid_rand <= rd_done & ~rd_done_bulk;   // back to the granted port
      rd_valid_bulk <= rd_done & rd_done_bulk;
    end
  end

  always_ff @(posedge CLK)
  begin
    pipe_bulk[0] <= dp_op.bulk;
    for (int i = 1; i < CAS_LATENCY; i++)
      pipe_bulk[i] <= pipe_bulk[i-1];
    if (rd_done)
      rd_data <= dq_in;   // CAS latency reached
  end

endmodule

`default_nettype wire

// ==== rtl/sdram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top #(
  parameter int REFRESH_CYCLES = 200,
  parameter int T_RP           = 2,
  parameter int T_RCD          = 2,
  parameter int T_RFC          = 6,
  parameter int CAS_LATENCY    = 2
) (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire sdram_pkg::port_req_t      req_rand,
  input  wire sdram_pkg::port_req_t      req_bulk,
  input  wire [sdram_pkg::DATA_W-1:0]    dq_in,
  output sdram_pkg::sdram_pins_t         pins,
  output logic [sdram_pkg::DATA_W-1:0]   dq_out,
  output logic                           dq_oe,
  output logic [sdram_pkg::BE_W-1:0]     dm,
  output logic                           grant_rand,
  output logic                           grant_bulk,
  output logic [sdram_pkg::DATA_W-1:0]   rd_data,
  output logic                           rd_valid_rand,
  output logic                           rd_valid_bulk
);

  logic              refresh_due;
  logic              refresh_ack;
  sdram_pkg::dp_op_t dp_op;   // sequencer to datapath

  refresh_timer #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_refresh_timer (
    .CLK         (CLK),
    .RST         (RST),
    .refresh_ack (refresh_ack),
    .refresh_due (refresh_due)
  );

  command_sequencer #(
    .T_RP  (T_RP),
    .T_RCD (T_RCD),
    .T_RFC (T_RFC)
  ) i_command_sequencer (
    .CLK         (CLK),
    .RST         (RST),
    .req_rand    (req_rand),
    .req_bulk    (req_bulk),
    .refresh_due (refresh_due),
    .refresh_ack (refresh_ack),
    .pins        (pins),
    .grant_rand  (grant_rand),
    .grant_bulk  (grant_bulk),
    .dp_op       (dp_op)
  );

  dq_datapath #(
    .CAS_LATENCY (CAS_LATENCY)
  ) i_dq_datapath (
    .CLK           (CLK),
    .RST           (RST),
    .dp_op         (dp_op),
    .dq_in         (dq_in),
    .dq_out        (dq_out),
    .dq_oe         (dq_oe),
    .dm            (dm),
    .rd_data       (rd_data),
    .rd_valid_rand (rd_valid_rand),
    .rd_valid_bulk (rd_valid_bulk)
  );

endmodule

`default_nettype wire

// ==== verif/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;

  localparam int REFRESH_CYCLES = 200;
  localparam int T_RP           = 2;
  localparam int T_RCD          = 2;
  localparam int T_RFC          = 6;
  localparam int CAS_LATENCY    = 2;
  localparam int N_ENTRIES      = 12;
  localparam int IDLE_CYCLES    = 260;
  localparam int WATCHDOG       = N_ENTRIES * 40 + 8 + 80 + IDLE_CYCLES;

  typedef struct packed {
    logic        bulk;
    logic        write;
    logic [25:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp;   // filled in for reads as the table runs
  } entry_t;

  logic                   CLK;
  logic                   RST;
  sdram_pkg::port_req_t   req_rand;
  sdram_pkg::port_req_t   req_bulk;
  logic [31:0]            dq_in;
  sdram_pkg::sdram_pins_t pins;
  logic [31:0]            dq_out;
  logic                   dq_oe;
  logic [3:0]             dm;
  logic                   grant_rand;
  logic                   grant_bulk;
  logic [31:0]            rd_data;
  logic                   rd_valid_rand;
  logic                   rd_valid_bulk;

  entry_t      tbl [N_ENTRIES];
  logic [31:0] mem [logic [25:0]];          // SDRAM model contents
  logic [31:0] expect_mem [logic [25:0]];   // reference for the table
  logic [31:0] lfsr_state;
  logic [3:0]  bank_open;
  logic [11:0] open_row [4];
  int          noop_run;
  int          noop_need;
  int          since_ref;
  int          actv_cnt;
  int          arsr_cnt;
  int          last_actv;
  int          last_arsr;
  logic [13:0] prev_page;
  logic        prev_valid;

  sdram_ctrl_top #(
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .T_RP           (T_RP),
    .T_RCD          (T_RCD),
    .T_RFC          (T_RFC),
    .CAS_LATENCY    (CAS_LATENCY)
  ) i_dut (
    .CLK           (CLK),
    .RST           (RST),
    .req_rand      (req_rand),
    .req_bulk      (req_bulk),
    .dq_in         (dq_in),
    .pins          (pins),
    .dq_out        (dq_out),
    .dq_oe         (dq_oe),
    .dm            (dm),
    .grant_rand    (grant_rand),
    .grant_bulk    (grant_bulk),
    .rd_data       (rd_data),
    .rd_valid_rand (rd_valid_rand),
    .rd_valid_bulk (rd_valid_bulk)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic fail_now(input string msg);
    $display("TEST FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        b;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      b          = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
      bits       = {bits[30:0], b};
    end
    return bits;
  endfunction

  function automatic logic [25:0] mk_addr(input int row, input int bank, input int col);
    return {row[11:0], bank[1:0], col[11:0]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++)
      if (be[b])
        w[8*b +: 8] = wd[8*b +: 8];
    return w;
  endfunction

  // SDRAM model and protocol checks
  always @(posedge CLK)
  begin
    logic [25:0] key;
    logic [31:0] word;
    logic [31:0] dly [CAS_LATENCY-1];
    if (!RST)
    begin
      bank_open <= '0;
      noop_run  <= 100;
      noop_need <= 0;
      since_ref <= 0;
      actv_cnt  <= 0;
      arsr_cnt  <= 0;
      dq_in     <= '0;
    end
    else
    begin
      word = '0;
      assert (!(grant_rand && grant_bulk))
        else fail_now("both grant lines high in one cycle");
      assert ((grant_rand || grant_bulk) ==
              (pins.cmd == sdram_pkg::READ || pins.cmd == sdram_pkg::WRTE))
        else fail_now("grant does not line up with READ or WRITE on the pins");
      assert (dq_oe == (pins.cmd == sdram_pkg::WRTE))
        else fail_now($sformatf("error: dq_oe %0h with pins.cmd %0h", dq_oe, pins.cmd));
      assert (since_ref <= REFRESH_CYCLES + 40)
        else fail_now("no auto refresh within the refresh interval");
      since_ref <= since_ref + 1;
      if (pins.cmd == sdram_pkg::NOOP)
        noop_run <= noop_run + 1;
      else
      begin
        assert (noop_run >= noop_need)
          else fail_now($sformatf("error: pins.cmd %0h after %0h NOOPs, need %0h",
                                  pins.cmd, noop_run, noop_need));
        noop_run <= 0;
      end
      case (pins.cmd)
        sdram_pkg::PRCH:
        begin
          bank_open <= '0;
          noop_need <= T_RP;
        end
        sdram_pkg::ACTV:
        begin
          assert (bank_open == '0)
            else fail_now("row activated with a page still open");
          bank_open[pins.bank] <= 1'b1;
          open_row[pins.bank]  <= pins.addr[11:0];
          actv_cnt             <= actv_cnt + 1;
          noop_need            <= T_RCD;
        end
        sdram_pkg::ARSR:
        begin
          assert (bank_open == '0)
            else fail_now("auto refresh issued with a page still open");
          arsr_cnt  <= arsr_cnt + 1;
          since_ref <= 0;
          noop_need <= T_RFC;
        end
        sdram_pkg::READ, sdram_pkg::WRTE:
        begin
          assert (bank_open[pins.bank])
            else fail_now("access issued to a bank with no open row");
          assert (pins.addr[10] == 1'b0)
            else fail_now($sformatf("error: pins.addr %0h has A10 set", pins.addr));
          noop_need <= 1;
          key  = {open_row[pins.bank], pins.bank, pins.addr[12:11], pins.addr[9:0]};
          word = mem.exists(key) ? mem[key] : 32'h0;
          if (pins.cmd == sdram_pkg::WRTE)
          begin
            mem[key] = merge_bytes(word, dq_out, ~dm);
          end
        end
        default: ;
      endcase
      // read data goes out so that the DUT samples it CAS_LATENCY after READ
      for (int i = CAS_LATENCY - 2; i > 0; i--)
        dly[i] = dly[i-1];
      dly[0] = (pins.cmd == sdram_pkg::READ) ? word : 32'h0;
      dq_in <= dly[CAS_LATENCY-2];
    end
  end

  task automatic run_entry(input int idx);
    entry_t      e;
    logic [31:0] old;
    e = tbl[idx];
    @(posedge CLK);
    if (e.bulk)
      req_bulk <= {1'b1, e.write, e.addr, e.wdata, e.be};
    else
      req_rand <= {1'b1, e.write, e.addr, e.wdata, e.be};
    do
      @(posedge CLK);
    while (!(e.bulk ? grant_bulk : grant_rand));
    req_bulk <= '0;
    req_rand <= '0;
    // a page hit needs no ACTV and a new page exactly one
    if (prev_valid && arsr_cnt == last_arsr)
    begin
      if (e.addr[25:12] == prev_page)
        assert (actv_cnt == last_actv)
          else fail_now($sformatf("error: ACTV count %0h on a page hit", actv_cnt - last_actv));
      else
        assert (actv_cnt == last_actv + 1)
          else fail_now($sformatf("error: ACTV count %0h on a page miss",
                                  actv_cnt - last_actv));
    end
    prev_valid = 1'b1;
    prev_page  = e.addr[25:12];
    last_actv  = actv_cnt;
    last_arsr  = arsr_cnt;
    old = expect_mem.exists(e.addr) ? expect_mem[e.addr] : 32'h0;
    if (e.write)
      expect_mem[e.addr] = merge_bytes(old, e.wdata, e.be);
    else
    begin
      tbl[idx].exp = old;
      do
      begin
        @(posedge CLK);
        assert (!(e.bulk ? rd_valid_rand : rd_valid_bulk))
          else fail_now("read valid pulsed on the port that did not request");
      end
      while (!(e.bulk ? rd_valid_bulk : rd_valid_rand));
      assert (rd_data == tbl[idx].exp)
        else fail_now($sformatf("error: rd_data %0h expected %0h at addr %0h",
                                rd_data, tbl[idx].exp, e.addr));
    end
  endtask

  // both ports read at once and bulk goes first
  task automatic run_pair(input logic [25:0] addr_r, input logic [25:0] addr_b);
    logic got_r;
    logic got_b;
    logic val_r;
    logic val_b;
    got_r = 1'b0;
    got_b = 1'b0;
    val_r = 1'b0;
    val_b = 1'b0;
    @(posedge CLK);
    req_rand <= {1'b1, 1'b0, addr_r, 32'h0, 4'h0};
    req_bulk <= {1'b1, 1'b0, addr_b, 32'h0, 4'h0};
    while (!(val_r && val_b))
    begin
      @(posedge CLK);
      if (grant_bulk)
      begin
        assert (!got_r) else fail_now("random port granted ahead of bulk");
        got_b = 1'b1;
        req_bulk <= '0;
      end
      if (grant_rand)
      begin
        got_r = 1'b1;
        req_rand <= '0;
      end
      if (rd_valid_bulk)
      begin
        val_b = 1'b1;
        assert (rd_data == expect_mem[addr_b])
          else fail_now($sformatf("error: rd_data %0h expected %0h", rd_data,
                                  expect_mem[addr_b]));
      end
      if (rd_valid_rand)
      begin
        assert (val_b) else fail_now("random read returned ahead of bulk");
        val_r = 1'b1;
        assert (rd_data == expect_mem[addr_r])
          else fail_now($sformatf("error: rd_data %0h expected %0h", rd_data,
                                  expect_mem[addr_r]));
      end
    end
    prev_valid = 1'b0;
  endtask

  initial
  begin
    repeat (WATCHDOG) @(posedge CLK);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired before the tests finished");
  end

  initial
  begin
    RST        = 1'b0;
    req_rand   = '0;
    req_bulk   = '0;
    dq_in      = '0;
    lfsr_state = 32'h54bbf3c7;
    prev_valid = 1'b0;
    prev_page  = '0;
    last_actv  = 0;
    last_arsr  = 0;
    // bulk, write, addr, data, byte enables, expected
    tbl[0]  = {1'b0, 1'b1, mk_addr(1, 0, 12'h005), take_bits(32), 4'hf, 32'h0};
    tbl[1]  = {1'b0, 1'b0, mk_addr(1, 0, 12'h005), 32'h0, 4'h0, 32'h0};
    tbl[2]  = {1'b1, 1'b1, mk_addr(1, 0, 12'h800), take_bits(32), 4'h5, 32'h0};
    tbl[3]  = {1'b1, 1'b0, mk_addr(1, 0, 12'h800), 32'h0, 4'h0, 32'h0};
    tbl[4]  = {1'b0, 1'b1, mk_addr(2, 1, 12'h003), take_bits(32), 4'hc, 32'h0};
    tbl[5]  = {1'b1, 1'b0, mk_addr(2, 1, 12'h003), 32'h0, 4'h0, 32'h0};
    tbl[6]  = {1'b0, 1'b0, mk_addr(2, 1, 12'h007), 32'h0, 4'h0, 32'h0};
    tbl[7]  = {1'b1, 1'b1, mk_addr(1, 0, 12'h005), take_bits(32), 4'h3, 32'h0};
    tbl[8]  = {1'b0, 1'b0, mk_addr(1, 0, 12'h005), 32'h0, 4'h0, 32'h0};
    tbl[9]  = {1'b1, 1'b1, mk_addr(3, 2, 12'h400), take_bits(32), 4'hf, 32'h0};
    tbl[10] = {1'b0, 1'b0, mk_addr(3, 2, 12'h400), 32'h0, 4'h0, 32'h0};
    tbl[11] = {1'b1, 1'b0, mk_addr(1, 0, 12'h005), 32'h0, 4'h0, 32'h0};
    repeat (8) @(posedge CLK);
    assert (pins.cmd == sdram_pkg::NOOP && pins.addr == 13'h0400)
      else fail_now($sformatf("error: pins %0h after reset", pins));
    assert (!grant_rand && !grant_bulk && !dq_oe && !rd_valid_rand && !rd_valid_bulk)
      else fail_now("grant, valid or dq_oe output high in reset");
    assert (dm == 4'hf) else fail_now($sformatf("error: dm %0h in reset", dm));
    RST <= 1'b1;
    for (int i = 0; i < N_ENTRIES; i++)
      run_entry(i);
    run_pair(mk_addr(2, 1, 12'h003), mk_addr(3, 2, 12'h400));
    repeat (IDLE_CYCLES - 20) @(posedge CLK);   // long enough for a refresh
    if (arsr_cnt == 0)
      fail_now("no auto refresh seen during the run");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/sdram_pkg.sv
rtl/refresh_timer.sv
rtl/command_sequencer.sv
rtl/dq_datapath.sv
rtl/sdram_ctrl_top.sv
verif/tb_sdram_ctrl.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert --top-module tb_sdram_ctrl \
		-f sim.f -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir
